// File: Makefile
TOP = tb_spi_master

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

obj_dir/V$(TOP): list.f *.sv *.svh
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP)

# Log is searched for the pass line, grep sets the exit status
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: list.f
+incdir+.
spi_bus_pkg.sv
spi_serial_pkg.sv
spi_apb_regs.sv
spi_shift_engine.sv
spi_pin_driver.sv
spi_master_top.sv
tb_spi_master.sv

// File: spi_apb_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "spi_settings.svh"

module spi_apb_regs import spi_bus_pkg::*, spi_serial_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	// APB slave
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	output logic      pready,
	output logic      pslverr,
	// From shift engine
	input  logic      busy,
	input  logic      done_pulse,
	input  frame_t    rx_frame,
	// To engine and pin driver
	output logic      start,
	output frame_t    tx_frame,
	output logic      cpol,
	output logic      cpha,
	output logic      order,
	output ss_sel_t   select,
	output prescale_t prescale
);

	apb_data_t ctrl_q;		// Full CTRL word as written
	frame_t    rx_q;		// Last received frame
	logic      done_q;		// Sticky frame complete
	apb_data_t status;

	logic access;			// APB access phase
	logic mapped;			// Address hits a register
	logic locked;			// Frame running or about to start
	logic wr_ctrl;
	logic wr_tx;
	logic rd_status;

	assign access = psel && penable;
	assign locked = busy || start;	// Covers the cycle before busy rises

	always_comb begin
		case (paddr)
			REG_CTRL, REG_TXDATA, REG_RXDATA, REG_STATUS: mapped = 1'b1;
			default: mapped = 1'b0;
		endcase
	end

	// Writes during a frame are refused so config and data stay put
	assign wr_ctrl   = access && pwrite && (paddr == REG_CTRL) && !locked;
	assign wr_tx     = access && pwrite && (paddr == REG_TXDATA) && !locked;
	assign rd_status = access && !pwrite && (paddr == REG_STATUS);

	assign pready  = 1'b1;		// No wait states
	assign pslverr = access && (!mapped || (pwrite && locked &&
		(paddr == REG_CTRL || paddr == REG_TXDATA)));

	always_comb begin
		status = '0;
		status[STAT_BUSY_BIT] = busy;
		status[STAT_DONE_BIT] = done_q;
	end

	// Read mux without side effects
	always_comb begin
		case (paddr)
			REG_CTRL:   prdata = ctrl_q;
			REG_TXDATA: prdata = apb_data_t'(tx_frame);
			REG_RXDATA: prdata = apb_data_t'(rx_q);
			REG_STATUS: prdata = status;
			default:    prdata = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			ctrl_q <= '0;		// cpol 0 and disabled
			start  <= 1'b0;
			done_q <= 1'b0;
		end else begin
			if (wr_ctrl)
				ctrl_q <= pwdata;
			start <= wr_tx && ctrl_q[CTRL_EN_BIT];	// Launch next cycle
			if (done_pulse)
				done_q <= 1'b1;		// Set beats a same-cycle read
			else if (rd_status)
				done_q <= 1'b0;
		end
	end

	// Payload registers
	always_ff @(posedge clk) begin
		if (wr_tx)
			tx_frame <= pwdata[`SPI_FRAME_W-1:0];
		if (done_pulse)
			rx_q <= rx_frame;
	end

	assign cpol     = ctrl_q[CTRL_CPOL_BIT];
	assign cpha     = ctrl_q[CTRL_CPHA_BIT];
	assign order    = ctrl_q[CTRL_ORDER_BIT];
	assign select   = ctrl_q[CTRL_SEL_MSB:CTRL_SEL_LSB];
	assign prescale = ctrl_q[CTRL_PRE_MSB:CTRL_PRE_LSB];

	// Engine must be idle whenever a frame is launched
	a_start_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy);

endmodule

`default_nettype wire

// File: spi_bus_pkg.sv
`default_nettype none
`include "spi_settings.svh"

package spi_bus_pkg;

	typedef logic [`SPI_ADDR_W-1:0] apb_addr_t;	// Byte address
	typedef logic [31:0] apb_data_t;			// APB data word

	// Register map
	typedef enum logic [`SPI_ADDR_W-1:0] {
		REG_CTRL   = 4'h0,
		REG_TXDATA = 4'h4,	// Write starts a frame
		REG_RXDATA = 4'h8,
		REG_STATUS = 4'hC	// Read clears done
	} spi_reg_e;

	// CTRL field layout
	localparam int CTRL_EN_BIT    = 0;
	localparam int CTRL_CPOL_BIT  = 1;
	localparam int CTRL_CPHA_BIT  = 2;
	localparam int CTRL_ORDER_BIT = 3;	// 1 is MSB first
	localparam int CTRL_SEL_LSB   = 4;
	localparam int CTRL_SEL_MSB   = 5;
	localparam int CTRL_PRE_LSB   = 16;
	localparam int CTRL_PRE_MSB   = 31;

	// STATUS layout
	localparam int STAT_BUSY_BIT = 0;
	localparam int STAT_DONE_BIT = 1;

endpackage

`default_nettype wire

// File: spi_master_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "spi_settings.svh"

module spi_master_top import spi_bus_pkg::*, spi_serial_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  apb_addr_t              paddr,
	input  apb_data_t              pwdata,
	output apb_data_t              prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  logic                   miso,
	output logic                   sck,
	output logic                   mosi,
	output logic [`SPI_NUM_SS-1:0] ss_n
);

	// Regs to engine
	logic      start;
	frame_t    tx_frame;
	logic      cpha;
	logic      order;
	prescale_t prescale;
	// Regs to driver
	logic      cpol;
	ss_sel_t   select;
	// Engine outputs
	logic      busy;
	logic      done_pulse;
	frame_t    rx_frame;
	logic      sck_phase;
	logic      active;
	logic      mosi_bit;

	spi_apb_regs u_regs (.clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .busy, .done_pulse, .rx_frame, .start,
		.tx_frame, .cpol, .cpha, .order, .select, .prescale);

	spi_shift_engine u_engine (.clk, .rst, .start, .tx_frame, .cpha, .order,
		.prescale, .miso, .busy, .done_pulse, .rx_frame, .sck_phase, .active,
		.mosi_bit);

	spi_pin_driver u_pins (.clk, .rst, .active, .sck_phase, .mosi_bit, .cpol,
		.select, .sck, .mosi, .ss_n);

endmodule

`default_nettype wire

// File: spi_pin_driver.sv
`timescale 1ns/1ps
`default_nettype none
`include "spi_settings.svh"

module spi_pin_driver import spi_serial_pkg::*; (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   active,		// Frame running
	input  logic                   sck_phase,
	input  logic                   mosi_bit,
	input  logic                   cpol,
	input  ss_sel_t                select,
	output logic                   sck,
	output logic                   mosi,
	output logic [`SPI_NUM_SS-1:0] ss_n
);

	logic [`SPI_NUM_SS-1:0] ss_onehot;

	// Decode slave index
	assign ss_onehot = `SPI_NUM_SS'(1) << select;

	// One register stage on every pin keeps them aligned
	always_ff @(posedge clk) begin
		if (rst) begin
			sck  <= 1'b0;		// cpol resets to 0
			mosi <= 1'b1;
			ss_n <= '1;			// All deselected
		end else begin
			sck  <= sck_phase ^ cpol;			// Idle level is cpol
			mosi <= active ? mosi_bit : 1'b1;	// Line parks high
			ss_n <= active ? ~ss_onehot : '1;
		end
	end

	a_one_ss: assert property (@(posedge clk) disable iff (rst) $onehot0(~ss_n));

endmodule

`default_nettype wire

// File: spi_serial_pkg.sv
`default_nettype none
`include "spi_settings.svh"

package spi_serial_pkg;

	typedef logic [`SPI_FRAME_W-1:0] frame_t;				// One serial frame
	typedef logic [$clog2(`SPI_FRAME_W)-1:0] bit_idx_t;	// Position within a frame
	typedef logic [`SPI_PRESCALE_W-1:0] prescale_t;		// Half period length minus one
	typedef logic [$clog2(`SPI_NUM_SS)-1:0] ss_sel_t;		// Which slave

	// Frame sequencing
	//   ST_LEAD   one idle half period with SS low before the first edge
	//   ST_SHIFT  sixteen half periods carrying the edges
	//   ST_TAIL   one idle half period after the last edge
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LEAD,
		ST_SHIFT,
		ST_TAIL
	} shift_state_e;

endpackage

`default_nettype wire

// File: spi_settings.svh
`ifndef SPI_SETTINGS_SVH
`define SPI_SETTINGS_SVH

// Serial frame size in bits
`define SPI_FRAME_W 8

// Width of the clock prescale field in CTRL
`define SPI_PRESCALE_W 16

// Number of slave select lines
`define SPI_NUM_SS 4

// APB byte address width, four word registers
`define SPI_ADDR_W 4

`endif

// File: spi_shift_engine.sv
`timescale 1ns/1ps
`default_nettype none
`include "spi_settings.svh"

module spi_shift_engine import spi_serial_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      start,		// One cycle launch
	input  frame_t    tx_frame,		// Held by regs during the frame
	input  logic      cpha,
	input  logic      order,		// 1 is MSB first
	input  prescale_t prescale,
	input  logic      miso,
	output logic      busy,
	output logic      done_pulse,
	output frame_t    rx_frame,
	output logic      sck_phase,	// Unpolarized SCK
	output logic      active,
	output logic      mosi_bit
);

	localparam bit_idx_t IDX_MSB = bit_idx_t'(`SPI_FRAME_W - 1);

	shift_state_e state;
	prescale_t    cnt;			// Clocks into current half period
	bit_idx_t     idx;			// Bit on the wire
	logic         last_done;	// Trailing edge of final bit seen
	logic         samp_q;		// Delayed sample strobe
	bit_idx_t     samp_idx;		// Bit position for delayed sample
	frame_t       rx_q;

	logic     tick;
	logic     rise;
	logic     fall;
	logic     sample;
	logic     advance;
	bit_idx_t first_idx;
	bit_idx_t last_idx;
	bit_idx_t idx_step;

	assign tick = (state != ST_IDLE) && (cnt == prescale);	// Half period ends

	assign first_idx = order ? IDX_MSB : '0;
	assign last_idx  = order ? '0 : IDX_MSB;
	assign idx_step  = order ? idx - 1'b1 : idx + 1'b1;	// Down for MSB first

	// Leading and trailing edges of sck_phase
	assign rise = tick && ((state == ST_LEAD) ||
		(state == ST_SHIFT && !sck_phase && !last_done));
	assign fall = tick && (state == ST_SHIFT) && sck_phase;

	// cpha 0: sample on leading, shift on trailing
	// cpha 1: shift on leading (not the first), sample on trailing
	assign sample  = cpha ? fall : rise;
	assign advance = cpha ? (rise && state == ST_SHIFT) : (fall && idx != last_idx);

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= ST_IDLE;
			cnt        <= '0;
			idx        <= '0;
			sck_phase  <= 1'b0;
			last_done  <= 1'b0;
			done_pulse <= 1'b0;
			samp_q     <= 1'b0;
		end else begin
			done_pulse <= 1'b0;
			samp_q     <= sample;
			if (state == ST_IDLE)
				cnt <= '0;
			else
				cnt <= tick ? '0 : cnt + 1'b1;
			if (advance)
				idx <= idx_step;
			case (state)
				ST_IDLE: begin
					if (start) begin
						state     <= ST_LEAD;
						idx       <= first_idx;	// First bit shows during lead
						last_done <= 1'b0;
					end
				end
				ST_LEAD: begin
					if (tick) begin
						state     <= ST_SHIFT;
						sck_phase <= 1'b1;		// First leading edge
					end
				end
				ST_SHIFT: begin
					if (tick) begin
						if (sck_phase) begin
							sck_phase <= 1'b0;
							if (idx == last_idx)
								last_done <= 1'b1;
						end else if (last_done) begin
							state <= ST_TAIL;	// SCK stays idle
						end else begin
							sck_phase <= 1'b1;
						end
					end
				end
				ST_TAIL: begin
					if (tick) begin
						state      <= ST_IDLE;
						done_pulse <= 1'b1;		// Same cycle busy drops
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// MISO is sampled one clk after the internal edge,
	// which lines it up with the registered SCK pin
	always_ff @(posedge clk) begin
		samp_idx <= idx;
		if (samp_q)
			rx_q[samp_idx] <= miso;
	end

	assign busy      = (state != ST_IDLE);
	assign active    = (state != ST_IDLE);	// SS window, lead through tail
	assign mosi_bit  = tx_frame[idx];
	assign rx_frame  = rx_q;

	a_done_one: assert property (@(posedge clk) disable iff (rst)
		done_pulse |=> !done_pulse);
	a_sck_idle: assert property (@(posedge clk) disable iff (rst)
		(state == ST_IDLE) |-> !sck_phase);

endmodule

`default_nettype wire

// File: spi_tests.txt
# cpol cpha order select prescale master_byte slave_byte
# order 1 is MSB first, bytes in hex, half period is prescale+1 clocks
0 0 1 0 0 A5 3C
0 0 0 1 1 96 E1
0 1 1 2 2 5A C3
0 1 0 3 0 0F F0
1 0 1 0 3 81 7E
1 0 0 1 0 C6 39
1 1 1 2 1 D2 2D
1 1 0 3 4 01 80
0 0 1 3 5 FF 00
1 1 0 0 2 00 FF
0 1 1 1 7 6B B6
1 0 0 2 1 E4 27

// File: tb_spi_master.sv
`timescale 1ns/1ps
`default_nettype none
`include "spi_settings.svh"

module tb_spi_master import spi_bus_pkg::*, spi_serial_pkg::*; ();

	localparam int CLK_PERIOD = 4;
	localparam int POLL_LIMIT = 100;	// STATUS reads per frame

	logic                   clk;
	logic                   rst;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	apb_addr_t              paddr;
	apb_data_t              pwdata;
	apb_data_t              prdata;
	logic                   pready;
	logic                   pslverr;
	logic                   miso;
	logic                   sck;
	logic                   mosi;
	logic [`SPI_NUM_SS-1:0] ss_n;

	// Current transfer as seen by the slave model
	logic                   cur_cpol;
	logic                   cur_cpha;
	logic                   cur_order;		// 1 is MSB first
	ss_sel_t                cur_sel;
	prescale_t              cur_pre;
	frame_t                 cur_mb;			// Master byte
	frame_t                 cur_sb;			// Slave byte
	logic [`SPI_NUM_SS-1:0] ss_expect;
	time                    hp_expect;		// SCK half period in ns

	// Slave model state
	logic   in_frame;
	frame_t cap_byte;
	int     cap_cnt;
	int     tx_cnt;
	int     edge_cnt;
	time    last_edge_t;

	int n_errors;
	int n_tests;

	spi_master_top dut (.clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .miso, .sck, .mosi, .ss_n);

	always #2 clk = ~clk;

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		n_errors++;
		$display("MISMATCH t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
	endtask

	// Setup cycle then access cycle with the response taken mid access
	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
		@(posedge clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b1;
		paddr   = addr;
		pwdata  = data;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#1;
		err = pslverr;
		if (pready !== 1'b1)
			report_mismatch("pready", 32'(pready), 32'h1);
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
		@(posedge clk);
		#1;
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = addr;
		@(posedge clk);
		#1;
		penable = 1'b1;
		#1;
		data = prdata;
		err  = pslverr;
		if (pready !== 1'b1)
			report_mismatch("pready", 32'(pready), 32'h1);
		@(posedge clk);
		#1;
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	// Bounded poll until STATUS.done
	task automatic wait_done(output logic ok, output apb_data_t stat);
		logic err;
		ok   = 1'b0;
		stat = '0;
		for (int i = 0; i < POLL_LIMIT && !ok; i++) begin
			apb_read(REG_STATUS, stat, err);
			if (stat[STAT_DONE_BIT] === 1'b1)
				ok = 1'b1;
		end
	endtask

	// n-th bit on the wire to its position in the byte
	function automatic bit_idx_t bit_pos(input int n);
		return cur_order ? bit_idx_t'(`SPI_FRAME_W - 1 - n) : bit_idx_t'(n);
	endfunction

	task automatic shift_in_mosi;
		if (cap_cnt < `SPI_FRAME_W)
			cap_byte[bit_pos(cap_cnt)] = mosi;
		cap_cnt++;
	endtask

	task automatic shift_out_miso;
		if (tx_cnt < `SPI_FRAME_W)
			miso = cur_sb[bit_pos(tx_cnt)];
		tx_cnt++;
	endtask

	// Slave select window
	always @(ss_n) begin
		if (!in_frame && !$isunknown(ss_n) && ss_n != '1) begin
			in_frame    = 1'b1;
			cap_cnt     = 0;
			tx_cnt      = 0;
			edge_cnt    = 0;
			last_edge_t = $time;	// Lead half period counts from here
			if (ss_n !== ss_expect)
				report_mismatch("ss_n at select", 32'(ss_n), 32'(ss_expect));
			if (!cur_cpha) begin
				#1;
				shift_out_miso();	// First bit before first edge
			end
		end else if (in_frame && ss_n === '1) begin
			in_frame = 1'b0;
			// Last low half period plus tail
			if ($time - last_edge_t != 2 * hp_expect)
				report_mismatch("tail length", 32'($time - last_edge_t), 32'(2 * hp_expect));
		end
	end

	// SCK edges inside the window
	always @(sck) begin
		if (in_frame) begin
			if ($time - last_edge_t != hp_expect)
				report_mismatch("sck half period", 32'($time - last_edge_t), 32'(hp_expect));
			last_edge_t = $time;
			edge_cnt++;
			if (ss_n !== ss_expect)
				report_mismatch("ss_n during frame", 32'(ss_n), 32'(ss_expect));
			if (sck !== cur_cpol) begin		// Leading edge
				if (cur_cpha) begin
					#1;
					shift_out_miso();
				end else begin
					shift_in_mosi();
				end
			end else begin					// Trailing edge
				if (cur_cpha) begin
					shift_in_mosi();
				end else begin
					#1;
					shift_out_miso();
				end
			end
		end
	end

	task automatic check_idle_pins(input string when);
		if (sck !== cur_cpol)
			report_mismatch({"sck ", when}, 32'(sck), 32'(cur_cpol));
		if (mosi !== 1'b1)
			report_mismatch({"mosi ", when}, 32'(mosi), 32'h1);
		if (ss_n !== '1)
			report_mismatch({"ss_n ", when}, 32'(ss_n), 32'hF);
	endtask

	// One full frame with the cur_* configuration
	task automatic run_transfer(output logic ok);
		apb_data_t rdata;
		logic      err;
		int        gap;
		ss_expect          = '1;
		ss_expect[cur_sel] = 1'b0;		// Only the addressed slave goes low
		hp_expect = time'((int'(cur_pre) + 1) * CLK_PERIOD);
		apb_write(REG_CTRL, {cur_pre, 10'b0, cur_sel, cur_order, cur_cpha, cur_cpol, 1'b1}, err);
		if (err !== 1'b0)
			report_mismatch("pslverr on CTRL write", 32'(err), 32'h0);
		gap = 1 + int'($urandom_range(3, 0));
		repeat (gap) @(posedge clk);
		#1;
		check_idle_pins("idle before frame");	// New polarity reached the pin
		cap_cnt  = 0;
		edge_cnt = 0;
		apb_write(REG_TXDATA, 32'(cur_mb), err);
		if (err !== 1'b0)
			report_mismatch("pslverr on TXDATA write", 32'(err), 32'h0);
		apb_read(REG_STATUS, rdata, err);
		if (rdata[STAT_BUSY_BIT] !== 1'b1)
			report_mismatch("STATUS.busy after start", 32'(rdata[STAT_BUSY_BIT]), 32'h1);
		apb_write(REG_TXDATA, 32'(~cur_mb), err);	// Must bounce off the running frame
		if (err !== 1'b1)
			report_mismatch("pslverr on busy TXDATA write", 32'(err), 32'h1);
		wait_done(ok, rdata);
		if (!ok) begin
			n_errors++;
			$display("Timeout: STATUS.done never set in transfer %0d", n_tests);
		end else begin
			if (rdata[1:0] !== 2'b10)
				report_mismatch("STATUS at done", 32'(rdata[1:0]), 32'h2);
			apb_read(REG_STATUS, rdata, err);
			if (rdata[STAT_DONE_BIT] !== 1'b0)
				report_mismatch("STATUS.done after read", 32'(rdata[STAT_DONE_BIT]), 32'h0);
			apb_read(REG_RXDATA, rdata, err);
			if (rdata !== 32'(cur_sb))
				report_mismatch("RXDATA", rdata, 32'(cur_sb));
			if (cap_byte !== cur_mb)
				report_mismatch("slave captured byte", 32'(cap_byte), 32'(cur_mb));
			if (cap_cnt != `SPI_FRAME_W)
				report_mismatch("slave bit count", 32'(cap_cnt), 32'(`SPI_FRAME_W));
			if (edge_cnt != 2 * `SPI_FRAME_W)
				report_mismatch("sck edge count", 32'(edge_cnt), 32'(2 * `SPI_FRAME_W));
			check_idle_pins("after done");
		end
	endtask

	initial begin
		int        fd;
		int        n_fields;
		int        f [7];
		string     line;
		apb_data_t rdata;
		logic      err;
		logic      ok;
		clk       = 1'b0;
		rst       = 1'b1;
		psel      = 1'b0;
		penable   = 1'b0;
		pwrite    = 1'b0;
		paddr     = '0;
		pwdata    = '0;
		miso      = 1'b1;
		in_frame  = 1'b0;
		cur_cpol  = 1'b0;
		cur_cpha  = 1'b0;
		cur_order = 1'b1;
		cur_sel   = '0;
		cur_pre   = '0;
		n_errors  = 0;
		n_tests   = 0;
		ok        = 1'b1;
		void'($urandom(32'hac3f));		// Random gaps between transfers
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		check_idle_pins("after reset");

		// Register map basics
		apb_write(REG_CTRL, 32'h5A5A_003E, err);
		apb_read(REG_CTRL, rdata, err);
		if (rdata !== 32'h5A5A_003E)
			report_mismatch("CTRL readback", rdata, 32'h5A5A_003E);
		apb_write(4'h2, 32'h0000_00FF, err);
		if (err !== 1'b1)
			report_mismatch("pslverr on unmapped write", 32'(err), 32'h1);
		apb_read(4'hE, rdata, err);
		if (err !== 1'b1)
			report_mismatch("pslverr on unmapped read", 32'(err), 32'h1);

		fd = $fopen("spi_tests.txt", "r");
		if (fd == 0) begin
			n_errors++;
			$display("Could not open spi_tests.txt");
		end else begin
			while (!$feof(fd) && ok) begin
				line = "";
				n_fields = $fgets(line, fd);
				n_fields = $sscanf(line, "%d %d %d %d %d %h %h",
					f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
				if (n_fields == 7) begin		// Comment and blank lines skipped
					cur_cpol  = f[0][0];
					cur_cpha  = f[1][0];
					cur_order = f[2][0];
					cur_sel   = ss_sel_t'(f[3]);
					cur_pre   = prescale_t'(f[4]);
					cur_mb    = frame_t'(f[5]);
					cur_sb    = frame_t'(f[6]);
					n_tests++;
					run_transfer(ok);
				end
			end
			$fclose(fd);
		end
		if (n_tests == 0) begin
			n_errors++;
			$display("No transfers were read from spi_tests.txt");
		end

		$display("Transfers run: %0d, errors: %0d", n_tests, n_errors);
		if (n_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
